/* src.f */
+incdir+source
source/frontend_pkg.sv
source/fetch_bus_if.sv
source/fetch_unit.sv
source/inst_buffer.sv
source/dispatch_unit.sv
source/frontend_top.sv
testbench/inst_memory_model.sv
testbench/frontend_tb.sv

/* Makefile */
# Verilator flow for the instruction front end.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
FILELIST   ?= src.f
TOP        ?= frontend_tb
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal
FAIL_TEXT  ?= Test failed
PASS_TEXT  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/frontend_tb.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

module frontend_tb;

    localparam int PERIOD          = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int HOLD_CYCLES     = 40;
    localparam int CREDIT_CYCLES   = 120;
    localparam int CRED_W          = $clog2(`FETCH_WIDTH + 1);
    localparam int SEQ_INSTS       = 32;
    localparam int CLASS_INSTS     = 24;
    localparam int PRESSURE_INSTS  = 24;
    localparam int REDIRECT_INSTS  = 24;
    localparam int WAIT_INSTS      = 64;
    localparam int TEST_INSTS      = SEQ_INSTS + CLASS_INSTS + PRESSURE_INSTS
                                   + REDIRECT_INSTS + WAIT_INSTS + CREDIT_CYCLES;
    localparam int WATCHDOG_CYCLES = TEST_INSTS * 4 + HOLD_CYCLES + RESET_CYCLES + 100;
    localparam logic [`XLEN-1:0] REDIRECT_TARGET = 32'h0000_2040;

    // same encoding as inst_class_t.
    localparam logic [2:0] CLASS_ALU    = 3'd0;
    localparam logic [2:0] CLASS_LOAD   = 3'd1;
    localparam logic [2:0] CLASS_STORE  = 3'd2;
    localparam logic [2:0] CLASS_BRANCH = 3'd3;
    localparam logic [2:0] CLASS_OTHER  = 3'd4;

    logic                               clock;
    logic                               reset;
    logic                               redirect;
    logic [`XLEN-1:0]                   redirect_pc;
    logic [CRED_W-1:0]                  credits;
    logic                               bus_cyc;
    logic                               bus_stb;
    logic                               bus_ack;
    logic [`XLEN-1:0]                   bus_adr;
    logic [`XLEN-1:0]                   bus_dat;
    logic [`FETCH_WIDTH-1:0]            dispatch_valid;
    logic [`FETCH_WIDTH-1:0][`XLEN-1:0] dispatch_pc;
    logic [`FETCH_WIDTH-1:0][`XLEN-1:0] dispatch_inst;
    logic [`FETCH_WIDTH-1:0][2:0]       dispatch_class;

    integer           seed = 48166;
    int               error_count;
    int               test_count;
    int               tests_failed;
    int               dispatch_count;
    int               ack_count;
    int               wait_cycles;
    int               class_seen [5];
    logic             pending;
    logic [`XLEN-1:0] pending_adr;
    logic [`XLEN-1:0] expected_pc_q [$]; // next pc to be dispatched.

    frontend_top DUT (
        .clock(clock), .reset(reset),
        .bus_cyc(bus_cyc), .bus_stb(bus_stb), .bus_adr(bus_adr),
        .bus_dat(bus_dat), .bus_ack(bus_ack),
        .redirect(redirect), .redirect_pc(redirect_pc), .credits(credits),
        .dispatch_valid(dispatch_valid), .dispatch_pc(dispatch_pc),
        .dispatch_inst(dispatch_inst), .dispatch_class(dispatch_class)
    );

    inst_memory_model memory (
        .clock(clock), .reset(reset), .cyc(bus_cyc), .stb(bus_stb),
        .adr(bus_adr), .dat(bus_dat), .ack(bus_ack)
    );

    always #(PERIOD / 2) clock = ~clock;

    // the memory contents, word number selects the opcode table entry.
    function automatic logic [6:0] table_opcode(input logic [`XLEN-1:0] pc);
        logic [6:0] codes [8] = '{7'b0110011, 7'b0000011, 7'b0010011, 7'b0100011,
                                  7'b1100011, 7'b0110111, 7'b1101111, 7'b1110011};
        return codes[pc[4:2]];
    endfunction

    function automatic logic [2:0] table_class(input logic [`XLEN-1:0] pc);
        logic [2:0] classes [8] = '{CLASS_ALU, CLASS_LOAD, CLASS_ALU, CLASS_STORE,
                                    CLASS_BRANCH, CLASS_OTHER, CLASS_BRANCH, CLASS_OTHER};
        return classes[pc[4:2]];
    endfunction

    function automatic logic [`XLEN-1:0] expected_word(input logic [`XLEN-1:0] pc);
        return {pc[26:2] ^ {20'b0, pc[31:27]}, table_opcode(pc)};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // outputs are stable mid-cycle.
    always @(negedge clock) begin : dispatch_monitor
        int               lanes;
        logic [`XLEN-1:0] want;
        if (!reset) begin
            lanes = 0;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (dispatch_valid[i]) begin
                    assert (i == lanes) else
                        report_mismatch($sformatf("lane %0d valid after a gap", i));
                    lanes++;
                    want = expected_pc_q.pop_front();
                    assert (dispatch_pc[i] == want) else begin
                        report_mismatch($sformatf("pc %h, expected %h", dispatch_pc[i], want));
                        want = dispatch_pc[i]; // resync.
                    end
                    if (expected_pc_q.size() == 0) begin
                        expected_pc_q.push_back(want + 4);
                    end
                    assert (dispatch_inst[i] == expected_word(dispatch_pc[i])) else
                        report_mismatch($sformatf("inst %h at pc %h",
                                                  dispatch_inst[i], dispatch_pc[i]));
                    assert (dispatch_class[i] == table_class(dispatch_pc[i])) else
                        report_mismatch($sformatf("class %0d at pc %h",
                                                  dispatch_class[i], dispatch_pc[i]));
                    if (dispatch_class[i] < 3'd5) begin
                        class_seen[dispatch_class[i]]++;
                    end
                    dispatch_count++;
                end
            end
            assert (lanes <= int'(credits)) else
                report_mismatch($sformatf("%0d dispatched with %0d credits", lanes, credits));
            if (pending) begin
                assert (bus_cyc && bus_stb && bus_adr == pending_adr) else
                    report_mismatch("bus cycle changed before ack");
            end
            pending     = bus_cyc && bus_stb && !bus_ack;
            pending_adr = bus_adr;
            if (bus_ack) begin
                ack_count++;
            end else if (bus_cyc) begin
                wait_cycles++;
            end
        end
    end

    task automatic wait_dispatches(input int count, input string name);
        int target;
        int cycles;
        target = dispatch_count + count;
        cycles = 0;
        while (dispatch_count < target && cycles < count * 8 + 40) begin
            next_cycle();
            cycles++;
        end
        assert (dispatch_count >= target) else begin
            $display("%s: only %0d of %0d instructions were dispatched in time", name,
                     count - (target - dispatch_count), count);
            error_count++;
        end
    endtask

    task automatic close_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s had %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_sequential_fetch();
        int errors_before;
        errors_before = error_count;
        wait_dispatches(SEQ_INSTS, "sequential fetch"); // scoreboard starts at pc 0.
        close_test("sequential fetch", errors_before);
    endtask

    task automatic test_class_decode();
        int errors_before;
        errors_before = error_count;
        foreach (class_seen[c]) class_seen[c] = 0;
        wait_dispatches(CLASS_INSTS, "class decode");
        foreach (class_seen[c]) begin
            assert (class_seen[c] > 0) else report_mismatch($sformatf("class %0d never seen", c));
        end
        close_test("class decode", errors_before);
    endtask

    task automatic test_back_pressure();
        int errors_before;
        int held;
        errors_before = error_count;
        next_cycle();
        credits = '0;
        held    = dispatch_count;
        repeat (HOLD_CYCLES) next_cycle();
        assert (dispatch_count == held) else
            report_mismatch($sformatf("%0d dispatched with no credits", dispatch_count - held));
        credits = CRED_W'(`FETCH_WIDTH);
        wait_dispatches(PRESSURE_INSTS, "back-pressure");
        close_test("back-pressure", errors_before);
    endtask

    task automatic test_credit_limit();
        int errors_before;
        int start;
        errors_before = error_count;
        start         = dispatch_count;
        repeat (CREDIT_CYCLES) begin
            next_cycle();
            credits = CRED_W'($unsigned($random(seed)) % (`FETCH_WIDTH + 1));
        end
        next_cycle();
        credits = CRED_W'(`FETCH_WIDTH);
        assert (dispatch_count > start) else
            report_mismatch("nothing dispatched under random credits");
        close_test("credit limit", errors_before);
    endtask

    task automatic test_redirect();
        int errors_before;
        errors_before = error_count;
        next_cycle();
        redirect    = 1'b1;
        redirect_pc = REDIRECT_TARGET;
        expected_pc_q.delete();
        expected_pc_q.push_back(REDIRECT_TARGET); // old stream must not appear again.
        next_cycle();
        redirect = 1'b0;
        wait_dispatches(REDIRECT_INSTS, "redirect");
        close_test("redirect", errors_before);
    endtask

    task automatic test_wait_states();
        int errors_before;
        int acks_before;
        int waits_before;
        errors_before = error_count;
        acks_before   = ack_count;
        waits_before  = wait_cycles;
        wait_dispatches(WAIT_INSTS, "wait states");
        assert (wait_cycles - waits_before > ack_count - acks_before) else begin
            $display("wait states: the memory never stretched a bus cycle");
            error_count++;
        end
        close_test("wait states", errors_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired after %0d clock cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        redirect       = 1'b0;
        redirect_pc    = '0;
        credits        = CRED_W'(`FETCH_WIDTH);
        error_count    = 0;
        test_count     = 0;
        tests_failed   = 0;
        dispatch_count = 0;
        ack_count      = 0;
        wait_cycles    = 0;
        pending        = 1'b0;
        pending_adr    = '0;
        expected_pc_q.push_back('0);
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        test_sequential_fetch();
        test_class_decode();
        test_back_pressure();
        test_credit_limit();
        test_redirect();
        test_wait_states();
        $display("tests run %0d, tests with errors %0d, errors %0d, instructions %0d",
                 test_count, tests_failed, error_count, dispatch_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/inst_memory_model.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

module inst_memory_model #(
    parameter int SEED = 48166
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             cyc,
    input  logic             stb,
    input  logic [`XLEN-1:0] adr,
    output logic [`XLEN-1:0] dat,
    output logic             ack
);

    integer           seed = SEED;
    int               waits;
    logic             respond;
    logic [`XLEN-1:0] word;

    // opcode repeats every eight words, the address fills the upper bits.
    function automatic logic [`XLEN-1:0] word_at(input logic [`XLEN-1:0] a);
        logic [6:0] opcode;
        case (a[4:2])
            3'd0:    opcode = 7'b0110011;
            3'd1:    opcode = 7'b0000011;
            3'd2:    opcode = 7'b0010011;
            3'd3:    opcode = 7'b0100011;
            3'd4:    opcode = 7'b1100011;
            3'd5:    opcode = 7'b0110111;
            3'd6:    opcode = 7'b1101111;
            default: opcode = 7'b1110011;
        endcase
        return {a[26:2] ^ {20'b0, a[31:27]}, opcode};
    endfunction

    initial begin
        ack   = 1'b0;
        dat   = '0;
        waits = 0;
    end

    always @(posedge clock) begin
        respond = 1'b0;
        word    = word_at(adr);
        if (reset) begin
            waits = $unsigned($random(seed)) % 4;
        end else if (cyc && stb && !ack) begin
            if (waits == 0) begin
                respond = 1'b1;
                waits   = $unsigned($random(seed)) % 4; // wait states for the next word.
            end else begin
                waits = waits - 1;
            end
        end
        #2;
        ack = respond; // one cycle only.
        if (respond) begin
            dat = word;
        end
    end

endmodule

/* source/frontend_top.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

module frontend_top
    import frontend_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset,

    output logic                                  bus_cyc,
    output logic                                  bus_stb,
    output logic [`XLEN-1:0]                      bus_adr,
    input  logic [`XLEN-1:0]                      bus_dat,
    input  logic                                  bus_ack,

    input  logic                                  redirect,
    input  logic [`XLEN-1:0]                      redirect_pc,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0]     credits,

    output logic [`FETCH_WIDTH-1:0]               dispatch_valid,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]    dispatch_pc,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]    dispatch_inst,
    output inst_class_t [`FETCH_WIDTH-1:0]        dispatch_class
);

    inst_packet_t [`FETCH_WIDTH-1:0]         in_insts;
    inst_packet_t [`FETCH_WIDTH-1:0]         head_insts;
    logic [$clog2(`FETCH_WIDTH+1)-1:0]       num_accept;
    logic [$clog2(`FETCH_WIDTH+1)-1:0]       num_dispatch;
    logic [$clog2(`IBUF_DEPTH+1)-1:0]        open_entries;
    logic [$clog2(`IBUF_DEPTH+1)-1:0]        occupancy;

    fetch_bus_if fetch_bus ();

    // bus bundle to plain pins.
    assign bus_cyc         = fetch_bus.cyc;
    assign bus_stb         = fetch_bus.stb;
    assign bus_adr         = fetch_bus.adr;
    assign fetch_bus.dat_r = bus_dat;
    assign fetch_bus.ack   = bus_ack;

    fetch_unit fetch (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .bus          (fetch_bus.master),
        .in_insts     (in_insts),
        .num_accept   (num_accept),
        .open_entries (open_entries)
    );

    inst_buffer buffer (
        .clock        (clock),
        .reset        (reset),
        .flush        (redirect),
        .in_insts     (in_insts),
        .num_accept   (num_accept),
        .num_dispatch (num_dispatch),
        .head_insts   (head_insts),
        .open_entries (open_entries),
        .occupancy    (occupancy)
    );

    dispatch_unit dispatch (
        .flush          (redirect),
        .head_insts     (head_insts),
        .occupancy      (occupancy),
        .credits        (credits),
        .num_dispatch   (num_dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_pc    (dispatch_pc),
        .dispatch_inst  (dispatch_inst),
        .dispatch_class (dispatch_class)
    );

endmodule

/* source/dispatch_unit.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

module dispatch_unit
    import frontend_pkg::*;
(
    input  logic                                  flush,
    input  inst_packet_t [`FETCH_WIDTH-1:0]       head_insts,
    input  logic [$clog2(`IBUF_DEPTH+1)-1:0]      occupancy,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0]     credits,
    output logic [$clog2(`FETCH_WIDTH+1)-1:0]     num_dispatch,
    output logic [`FETCH_WIDTH-1:0]               dispatch_valid,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]    dispatch_pc,
    output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]    dispatch_inst,
    output inst_class_t [`FETCH_WIDTH-1:0]        dispatch_class
);

    localparam int CNT_W = $clog2(`FETCH_WIDTH + 1);
    localparam int OCC_W = $clog2(`IBUF_DEPTH + 1);

    logic [CNT_W-1:0] limit;

    function automatic inst_class_t decode_class(input logic [6:0] opcode);
        case (opcode)
            7'b0110011, 7'b0010011: return class_alu;    // op, op-imm.
            7'b0000011:             return class_load;
            7'b0100011:             return class_store;
            7'b1100011, 7'b1101111: return class_branch; // branch, jal.
            default:                return class_other;
        endcase
    endfunction

    // smallest of occupancy, width and credits.
    always_comb begin
        if (occupancy < OCC_W'(`FETCH_WIDTH)) begin
            limit = CNT_W'(occupancy);
        end else begin
            limit = CNT_W'(`FETCH_WIDTH);
        end
        if (credits < limit) begin
            limit = credits;
        end
        num_dispatch = flush ? '0 : limit;
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            dispatch_valid[i] = i < int'(num_dispatch); // contiguous from lane 0.
            dispatch_pc[i]    = head_insts[i].pc;
            dispatch_inst[i]  = head_insts[i].inst;
            dispatch_class[i] = decode_class(head_insts[i].inst[6:0]);
        end
    end

endmodule

/* source/inst_buffer.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

module inst_buffer
    import frontend_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                flush,
    input  inst_packet_t [`FETCH_WIDTH-1:0]     in_insts,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0]   num_accept,
    input  logic [$clog2(`FETCH_WIDTH+1)-1:0]   num_dispatch,
    output inst_packet_t [`FETCH_WIDTH-1:0]     head_insts,
    output logic [$clog2(`IBUF_DEPTH+1)-1:0]    open_entries,
    output logic [$clog2(`IBUF_DEPTH+1)-1:0]    occupancy
);

    localparam int PTR_W = $clog2(`IBUF_DEPTH);
    localparam int OCC_W = $clog2(`IBUF_DEPTH + 1);

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] next_head;
    logic [PTR_W-1:0] next_tail;
    logic [OCC_W-1:0] num_entries;
    logic [OCC_W-1:0] next_num_entries;

    inst_packet_t [`IBUF_DEPTH-1:0] entries;

    // entries leaving this cycle count as free.
    assign open_entries = OCC_W'(`IBUF_DEPTH) - num_entries + OCC_W'(num_dispatch);
    assign occupancy    = num_entries;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            head_insts[i] = entries[(int'(head) + i) % `IBUF_DEPTH];
        end
    end

    always_comb begin
        next_head        = PTR_W'((int'(head) + int'(num_dispatch)) % `IBUF_DEPTH);
        next_tail        = PTR_W'((int'(tail) + int'(num_accept)) % `IBUF_DEPTH);
        next_num_entries = num_entries - OCC_W'(num_dispatch) + OCC_W'(num_accept);
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head        <= '0;
            tail        <= '0;
            num_entries <= '0;
        end else begin
            head        <= next_head;
            tail        <= next_tail;
            num_entries <= next_num_entries;
        end
    end

    // contents survive a flush, only the pointers move.
    always_ff @(posedge clock) begin
        for (int j = 0; j < `FETCH_WIDTH; j++) begin
            if (!flush && j < int'(num_accept)) begin
                entries[(int'(tail) + j) % `IBUF_DEPTH] <= in_insts[j];
            end
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

module fetch_unit
    import frontend_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                redirect,
    input  logic [`XLEN-1:0]                    redirect_pc,
    fetch_bus_if.master                         bus,
    output inst_packet_t [`FETCH_WIDTH-1:0]     in_insts,
    output logic [$clog2(`FETCH_WIDTH+1)-1:0]   num_accept,
    input  logic [$clog2(`IBUF_DEPTH+1)-1:0]    open_entries
);

    localparam int CNT_W  = $clog2(`FETCH_WIDTH + 1);
    localparam int OPEN_W = $clog2(`IBUF_DEPTH + 1);

    logic [`XLEN-1:0] fetch_pc;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] adr_q;
    logic             cyc_q;
    logic             discard_q;
    logic             ack_in;
    logic             keep_word;
    logic             cycle_done;
    logic             start_cycle;

    inst_packet_t [`FETCH_WIDTH-1:0] stage;
    inst_packet_t [`FETCH_WIDTH-1:0] next_stage;
    logic [CNT_W-1:0]                stage_count;
    logic [CNT_W-1:0]                remaining;
    logic [CNT_W-1:0]                next_count;

    // classic cycle, stb follows cyc.
    assign bus.cyc = cyc_q;
    assign bus.stb = cyc_q;
    assign bus.adr = adr_q;

    assign in_insts = stage;

    assign ack_in    = cyc_q && bus.ack;
    assign keep_word = ack_in && !discard_q && !redirect;

    // push as many staged words as the buffer can take.
    always_comb begin
        if (OPEN_W'(stage_count) <= open_entries) begin
            num_accept = stage_count;
        end else begin
            num_accept = CNT_W'(open_entries);
        end
    end

    assign remaining = stage_count - num_accept;

    always_comb begin
        next_stage = stage;
        next_count = remaining;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i + int'(num_accept) < `FETCH_WIDTH) begin
                next_stage[i] = stage[i + int'(num_accept)]; // shift out pushed words.
            end
        end
        if (keep_word && remaining < CNT_W'(`FETCH_WIDTH)) begin
            next_stage[remaining].pc   = adr_q;
            next_stage[remaining].inst = bus.dat_r;
            next_count                 = remaining + 1'b1;
        end
        if (redirect) begin
            next_count = '0;
        end
    end

    assign pc_next     = redirect ? redirect_pc : fetch_pc;
    assign cycle_done  = !cyc_q || ack_in;
    assign start_cycle = cycle_done && (next_count < CNT_W'(`FETCH_WIDTH)); // keep a free slot.

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc    <= '0;
            adr_q       <= '0;
            cyc_q       <= 1'b0;
            discard_q   <= 1'b0;
            stage_count <= '0;
        end else begin
            stage_count <= next_count;
            if (cycle_done) begin
                cyc_q <= start_cycle;
            end
            if (start_cycle) begin
                adr_q    <= pc_next;
                fetch_pc <= pc_next + `XLEN'd4;
            end else begin
                fetch_pc <= pc_next;
            end
            // a redirect during an open cycle drops the word still outstanding.
            if (ack_in) begin
                discard_q <= 1'b0;
            end else if (redirect && cyc_q) begin
                discard_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        stage <= next_stage;
    end

endmodule

/* source/fetch_bus_if.sv */
`timescale 1ns/1ps
`include "frontend_settings.svh"

interface fetch_bus_if;

    logic             cyc;
    logic             stb;
    logic [`XLEN-1:0] adr;
    logic [`XLEN-1:0] dat_r;
    logic             ack;

    modport master (
        output cyc,
        output stb,
        output adr,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  adr,
        output dat_r,
        output ack
    );

endinterface

/* source/frontend_pkg.sv */
`include "frontend_settings.svh"

package frontend_pkg;

    // one fetched instruction with its address.
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } inst_packet_t;

    // coarse class from the major opcode.
    typedef enum logic [2:0] {
        class_alu,
        class_load,
        class_store,
        class_branch,
        class_other
    } inst_class_t;

endpackage

/* source/frontend_settings.svh */
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// instructions moved per clock at each stage.
`define FETCH_WIDTH 2

// instruction buffer entries.
`define IBUF_DEPTH 8

// address and instruction word width.
`define XLEN 32

`endif
